//--- rtl/core_pkg.sv
package core_pkg;

	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;
	localparam int WINDOW_DEPTH = 3;

	typedef logic [4:0] reg_addr_t;
	typedef logic [XLEN-1:0] word_t;
	typedef logic [15:0] imm_t;

	// bit 0 for unit 1, bit 1 for unit 2
	typedef logic [1:0] unit_mask_t;

	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SLT  = 6'h06,
		OP_ADDI = 6'h08,
		OP_LUI  = 6'h09,
		OP_MUL  = 6'h0a
	} opcode_e;

	// src t lives in imm[15:11]
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t dest;
		reg_addr_t src_s;
		imm_t imm;
	} instr_t;

	typedef struct packed {
		opcode_e op;
		reg_addr_t ds;
		reg_addr_t dt;
		reg_addr_t dd;
		imm_t imm;
		unit_mask_t units;
	} decoded_t;

	// integer ops common to both units, mul excluded
	function automatic word_t alu_calc(opcode_e op, word_t s, word_t t, imm_t imm);
		word_t r;
		case (op)
			OP_ADD:  r = s + t;
			OP_SUB:  r = s - t;
			OP_AND:  r = s & t;
			OP_OR:   r = s | t;
			OP_XOR:  r = s ^ t;
			OP_SLT:  r = word_t'($signed(s) < $signed(t));
			OP_ADDI: r = s + {{(XLEN-16){imm[15]}}, imm};
			OP_LUI:  r = {imm, 16'h0000};
			default: r = '0;
		endcase
		return r;
	endfunction

endpackage

//--- rtl/issue_if.sv
interface issue_if;
	import core_pkg::*;

	logic vld;
	opcode_e op;
	word_t ds_val;
	word_t dt_val;
	reg_addr_t dd;
	imm_t imm;

	modport win (
		output vld,
		output op,
		output ds_val,
		output dt_val,
		output dd,
		output imm
	);

	modport unit (
		input vld,
		input op,
		input ds_val,
		input dt_val,
		input dd,
		input imm
	);

endinterface

//--- rtl/instr_decoder.sv
module instr_decoder (
	input core_pkg::instr_t i_instr,
	output core_pkg::decoded_t o_dec
);
	import core_pkg::*;

	reg_addr_t src_t;

	assign src_t = i_instr.imm[15:11];

	always_comb begin
		o_dec = '0;
		case (i_instr.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
				o_dec.op = opcode_e'(i_instr.opcode);
				o_dec.ds = i_instr.src_s;
				o_dec.dt = src_t;
				o_dec.dd = i_instr.dest;
				o_dec.units = 2'b11;
			end
			OP_MUL: begin
				o_dec.op = OP_MUL;
				o_dec.ds = i_instr.src_s;
				o_dec.dt = src_t;
				o_dec.dd = i_instr.dest;
				// multiplier only in unit 2
				o_dec.units = 2'b10;
			end
			OP_ADDI: begin
				o_dec.op = OP_ADDI;
				o_dec.ds = i_instr.src_s;
				o_dec.dd = i_instr.dest;
				o_dec.imm = i_instr.imm;
				o_dec.units = 2'b11;
			end
			OP_LUI: begin
				o_dec.op = OP_LUI;
				o_dec.dd = i_instr.dest;
				o_dec.imm = i_instr.imm;
				o_dec.units = 2'b11;
			end
			default: begin
				// no-op, no registers touched
				o_dec.op = OP_NOP;
				o_dec.units = 2'b11;
			end
		endcase
	end

endmodule

//--- rtl/issue_window.sv
module issue_window #(
	parameter int WINDOW_DEPTH = core_pkg::WINDOW_DEPTH
) (
	input logic clk,
	input logic rstn,
	input logic i_vld,
	input core_pkg::decoded_t i_dec0,
	input core_pkg::decoded_t i_dec1,
	input logic i_en1,
	output logic o_busy,
	input core_pkg::reg_addr_t i_wb0_addr,
	input core_pkg::reg_addr_t i_wb1_addr,
	output core_pkg::reg_addr_t o_rd_addr [2*WINDOW_DEPTH],
	input core_pkg::word_t i_rd_data [2*WINDOW_DEPTH],
	issue_if.win u1,
	issue_if.win u2
);
	import core_pkg::*;

	decoded_t ent [WINDOW_DEPTH];
	logic [WINDOW_DEPTH-1:0] ent_vld;
	logic [NUM_REGS-1:0] sb;

	logic [NUM_REGS-1:0] dst [WINDOW_DEPTH];
	logic [NUM_REGS-1:0] touch [WINDOW_DEPTH];
	logic [WINDOW_DEPTH-1:0] rdy;
	logic [WINDOW_DEPTH-1:0] u1_sel;
	logic [WINDOW_DEPTH-1:0] u2_sel;
	logic [WINDOW_DEPTH-1:0] issued;
	decoded_t nxt_ent [WINDOW_DEPTH];
	logic [WINDOW_DEPTH-1:0] nxt_vld;
	logic accept;
	logic [NUM_REGS-1:0] sb_set;
	logic [NUM_REGS-1:0] sb_clr;
	decoded_t u1_pick;
	decoded_t u2_pick;
	word_t u1_s;
	word_t u1_t;
	word_t u2_s;
	word_t u2_t;

	// r0 is never tracked
	function automatic logic [NUM_REGS-1:0] reg_bit(reg_addr_t a);
		logic [NUM_REGS-1:0] b;
		b = '0;
		b[a] = (a != '0);
		return b;
	endfunction

	always_comb begin
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			dst[i] = reg_bit(ent[i].dd);
			touch[i] = reg_bit(ent[i].ds) | reg_bit(ent[i].dt) | dst[i];
			o_rd_addr[2*i] = ent[i].ds;
			o_rd_addr[2*i+1] = ent[i].dt;
		end
	end

	// RAW and WAW against older dests, WAR against older sources
	always_comb begin
		logic [NUM_REGS-1:0] older_dst;
		logic [NUM_REGS-1:0] older_touch;
		older_dst = '0;
		older_touch = '0;
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			rdy[i] = ent_vld[i] && (((sb | older_dst) & touch[i]) == '0)
				&& ((older_touch & dst[i]) == '0);
			if (ent_vld[i]) begin
				older_dst = older_dst | dst[i];
				older_touch = older_touch | touch[i];
			end
		end
	end

	// oldest first, unit 1 picks before unit 2
	always_comb begin
		u1_sel = '0;
		u2_sel = '0;
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			if (rdy[i] && ent[i].units[0] && u1_sel == '0)
				u1_sel[i] = 1'b1;
		end
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			if (rdy[i] && ent[i].units[1] && !u1_sel[i] && u2_sel == '0)
				u2_sel[i] = 1'b1;
		end
		issued = u1_sel | u2_sel;
	end

	always_comb begin
		u1_pick = ent[0];
		u2_pick = ent[0];
		u1_s = i_rd_data[0];
		u1_t = i_rd_data[1];
		u2_s = i_rd_data[0];
		u2_t = i_rd_data[1];
		sb_set = '0;
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			if (u1_sel[i]) begin
				u1_pick = ent[i];
				u1_s = i_rd_data[2*i];
				u1_t = i_rd_data[2*i+1];
			end
			if (u2_sel[i]) begin
				u2_pick = ent[i];
				u2_s = i_rd_data[2*i];
				u2_t = i_rd_data[2*i+1];
			end
			if (issued[i])
				sb_set = sb_set | dst[i];
		end
		sb_clr = reg_bit(i_wb0_addr) | reg_bit(i_wb1_addr);
	end

	// compact survivors in age order, then append the new pair
	always_comb begin
		int cnt;
		cnt = 0;
		nxt_ent = ent;
		nxt_vld = '0;
		for (int i = 0; i < WINDOW_DEPTH; i++) begin
			if (ent_vld[i] && !issued[i]) begin
				nxt_ent[cnt] = ent[i];
				nxt_vld[cnt] = 1'b1;
				cnt++;
			end
		end
		o_busy = (cnt > WINDOW_DEPTH - 2);
		accept = i_vld && !o_busy;
		if (accept && cnt < WINDOW_DEPTH) begin
			nxt_ent[cnt] = i_dec0;
			nxt_vld[cnt] = 1'b1;
			cnt++;
		end
		if (accept && i_en1 && cnt < WINDOW_DEPTH) begin
			nxt_ent[cnt] = i_dec1;
			nxt_vld[cnt] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ent_vld <= '0;
			sb <= '0;
			u1.vld <= 1'b0;
			u2.vld <= 1'b0;
		end else begin
			ent_vld <= nxt_vld;
			sb <= (sb & ~sb_clr) | sb_set;
			u1.vld <= |u1_sel;
			u2.vld <= |u2_sel;
		end
	end

	always_ff @(posedge clk) begin
		ent <= nxt_ent;
		u1.op <= u1_pick.op;
		u1.ds_val <= u1_s;
		u1.dt_val <= u1_t;
		u1.dd <= u1_pick.dd;
		u1.imm <= u1_pick.imm;
		u2.op <= u2_pick.op;
		u2.ds_val <= u2_s;
		u2.dt_val <= u2_t;
		u2.dd <= u2_pick.dd;
		u2.imm <= u2_pick.imm;
	end

endmodule

//--- rtl/reg_file.sv
module reg_file #(
	parameter int NUM_RD = 2 * core_pkg::WINDOW_DEPTH
) (
	input logic clk,
	input logic rstn,
	input core_pkg::reg_addr_t i_rd_addr [NUM_RD],
	output core_pkg::word_t o_rd_data [NUM_RD],
	input core_pkg::reg_addr_t i_wb0_addr,
	input core_pkg::word_t i_wb0_data,
	input core_pkg::reg_addr_t i_wb1_addr,
	input core_pkg::word_t i_wb1_data,
	output core_pkg::reg_addr_t o_wb0_addr,
	output core_pkg::word_t o_wb0_data,
	output core_pkg::reg_addr_t o_wb1_addr,
	output core_pkg::word_t o_wb1_data
);
	import core_pkg::*;

	word_t mem [NUM_REGS];

	// no forwarding, r0 reads zero
	always_comb begin
		for (int i = 0; i < NUM_RD; i++)
			o_rd_data[i] = (i_rd_addr[i] == '0) ? '0 : mem[i_rd_addr[i]];
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			o_wb0_addr <= '0;
			o_wb1_addr <= '0;
		end else begin
			o_wb0_addr <= i_wb0_addr;
			o_wb1_addr <= i_wb1_addr;
		end
	end

	// array written from the wb stage, same edge the scoreboard clears
	always_ff @(posedge clk) begin
		o_wb0_data <= i_wb0_data;
		o_wb1_data <= i_wb1_data;
		if (o_wb0_addr != '0)
			mem[o_wb0_addr] <= o_wb0_data;
		if (o_wb1_addr != '0)
			mem[o_wb1_addr] <= o_wb1_data;
	end

endmodule

//--- rtl/alu_unit.sv
module alu_unit (
	input logic clk,
	input logic rstn,
	issue_if.unit issue,
	output core_pkg::reg_addr_t o_wb_addr,
	output core_pkg::word_t o_wb_data
);
	import core_pkg::*;

	word_t res;

	assign res = alu_calc(issue.op, issue.ds_val, issue.dt_val, issue.imm);

	// idle cycle writes nothing
	always_ff @(posedge clk) begin
		if (!rstn)
			o_wb_addr <= '0;
		else
			o_wb_addr <= issue.vld ? issue.dd : '0;
	end

	always_ff @(posedge clk) begin
		o_wb_data <= res;
	end

endmodule

//--- rtl/alu_mul_unit.sv
module alu_mul_unit (
	input logic clk,
	input logic rstn,
	issue_if.unit issue,
	output core_pkg::reg_addr_t o_wb_addr,
	output core_pkg::word_t o_wb_data
);
	import core_pkg::*;

	word_t prod;
	word_t res;
	reg_addr_t s1_dd;
	word_t s1_data;

	// low half of the product only
	assign prod = issue.ds_val * issue.dt_val;
	assign res = (issue.op == OP_MUL) ? prod
		: alu_calc(issue.op, issue.ds_val, issue.dt_val, issue.imm);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			s1_dd <= '0;
			o_wb_addr <= '0;
		end else begin
			s1_dd <= issue.vld ? issue.dd : '0;
			o_wb_addr <= s1_dd;
		end
	end

	// two in flight, one per stage
	always_ff @(posedge clk) begin
		s1_data <= res;
		o_wb_data <= s1_data;
	end

endmodule

//--- rtl/core_top.sv
module core_top #(
	parameter int WINDOW_DEPTH = core_pkg::WINDOW_DEPTH
) (
	input logic clk,
	input logic rstn,
	input logic i_vld,
	input core_pkg::instr_t i_instr0,
	input core_pkg::instr_t i_instr1,
	input logic i_en1,
	output logic o_busy,
	output core_pkg::reg_addr_t o_wb0_addr,
	output core_pkg::word_t o_wb0_data,
	output core_pkg::reg_addr_t o_wb1_addr,
	output core_pkg::word_t o_wb1_data
);
	import core_pkg::*;

	localparam int NUM_RD = 2 * WINDOW_DEPTH;

	decoded_t dec0;
	decoded_t dec1;
	reg_addr_t rd_addr [NUM_RD];
	word_t rd_data [NUM_RD];
	reg_addr_t u1_wb_addr;
	word_t u1_wb_data;
	reg_addr_t u2_wb_addr;
	word_t u2_wb_data;

	issue_if u1_if ();
	issue_if u2_if ();

	instr_decoder u_dec0 (
		.i_instr (i_instr0),
		.o_dec   (dec0)
	);

	instr_decoder u_dec1 (
		.i_instr (i_instr1),
		.o_dec   (dec1)
	);

	issue_window #(
		.WINDOW_DEPTH (WINDOW_DEPTH)
	) u_window (
		.clk        (clk),
		.rstn       (rstn),
		.i_vld      (i_vld),
		.i_dec0     (dec0),
		.i_dec1     (dec1),
		.i_en1      (i_en1),
		.o_busy     (o_busy),
		.i_wb0_addr (o_wb0_addr),
		.i_wb1_addr (o_wb1_addr),
		.o_rd_addr  (rd_addr),
		.i_rd_data  (rd_data),
		.u1         (u1_if.win),
		.u2         (u2_if.win)
	);

	reg_file #(
		.NUM_RD (NUM_RD)
	) u_regs (
		.clk        (clk),
		.rstn       (rstn),
		.i_rd_addr  (rd_addr),
		.o_rd_data  (rd_data),
		.i_wb0_addr (u1_wb_addr),
		.i_wb0_data (u1_wb_data),
		.i_wb1_addr (u2_wb_addr),
		.i_wb1_data (u2_wb_data),
		.o_wb0_addr (o_wb0_addr),
		.o_wb0_data (o_wb0_data),
		.o_wb1_addr (o_wb1_addr),
		.o_wb1_data (o_wb1_data)
	);

	alu_unit u_alu (
		.clk       (clk),
		.rstn      (rstn),
		.issue     (u1_if.unit),
		.o_wb_addr (u1_wb_addr),
		.o_wb_data (u1_wb_data)
	);

	alu_mul_unit u_alu_mul (
		.clk       (clk),
		.rstn      (rstn),
		.issue     (u2_if.unit),
		.o_wb_addr (u2_wb_addr),
		.o_wb_data (u2_wb_data)
	);

endmodule

//--- tests/issue_window_chk.sv
module issue_window_chk #(
	parameter int WINDOW_DEPTH = core_pkg::WINDOW_DEPTH
) (
	input logic clk,
	input logic rstn,
	input logic [WINDOW_DEPTH-1:0] u1_sel,
	input logic [WINDOW_DEPTH-1:0] u2_sel,
	input logic [core_pkg::NUM_REGS-1:0] sb,
	input logic [core_pkg::NUM_REGS-1:0] sb_set
);
	timeunit 1ns;
	timeprecision 1ps;

	// one entry goes to one unit at most
	a_single_dispatch: assert property (@(posedge clk) disable iff (!rstn)
		(u1_sel & u2_sel) == '0)
		else $error("window entry dispatched to both units");

	// r0 never tracked
	a_no_r0_busy: assert property (@(posedge clk) disable iff (!rstn)
		!sb[0])
		else $error("scoreboard bit for r0 is set");

	a_dest_was_free: assert property (@(posedge clk) disable iff (!rstn)
		(sb & sb_set) == '0)
		else $error("dispatch to a destination with a pending write");

endmodule

bind issue_window issue_window_chk #(
	.WINDOW_DEPTH (WINDOW_DEPTH)
) u_chk (
	.clk    (clk),
	.rstn   (rstn),
	.u1_sel (u1_sel),
	.u2_sel (u2_sel),
	.sb     (sb),
	.sb_set (sb_set)
);

//--- tests/tb_core.sv
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam logic [31:0] SEED = 32'h844b_3325;
	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int DEPTH = 3;
	localparam int NUM_MIXED = 200;
	localparam int NUM_BURST = 80;
	localparam int ACCEPT_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 500;

	logic clk = 1'b0;
	logic rstn;
	logic i_vld;
	instr_t i_instr0;
	instr_t i_instr1;
	logic i_en1;
	logic o_busy;
	reg_addr_t o_wb0_addr;
	word_t o_wb0_data;
	reg_addr_t o_wb1_addr;
	word_t o_wb1_data;

	instr_t prog [$];
	word_t model_regs [NUM_REGS];
	word_t exp_q [NUM_REGS][$];
	logic [5:0] alu_ops [8];
	int errors = 0;
	int expected_writes = 0;
	int seen_writes = 0;
	int busy_cycles = 0;
	bit ok;

	core_top #(
		.WINDOW_DEPTH (DEPTH)
	) dut (
		.clk        (clk),
		.rstn       (rstn),
		.i_vld      (i_vld),
		.i_instr0   (i_instr0),
		.i_instr1   (i_instr1),
		.i_en1      (i_en1),
		.o_busy     (o_busy),
		.o_wb0_addr (o_wb0_addr),
		.o_wb0_data (o_wb0_data),
		.o_wb1_addr (o_wb1_addr),
		.o_wb1_data (o_wb1_data)
	);

	always #(PERIOD / 2) clk = ~clk;

	// registers 0 to 7 only, so dependences are frequent
	function automatic instr_t random_instr(bit mul_heavy);
		instr_t ins;
		int pick;
		pick = $urandom_range(99);
		ins.dest = reg_addr_t'($urandom_range(7));
		ins.src_s = reg_addr_t'($urandom_range(7));
		ins.imm = 16'($urandom);
		if (pick < (mul_heavy ? 70 : 15))
			ins.opcode = OP_MUL;
		else if (pick < (mul_heavy ? 73 : 21))
			ins.opcode = (pick % 2 == 0) ? 6'h07 : 6'h3f;
		else
			ins.opcode = alu_ops[$urandom_range(7)];
		// src t sits in the top of the immediate
		if (ins.opcode != OP_ADDI && ins.opcode != OP_LUI)
			ins.imm[15:11] = reg_addr_t'($urandom_range(7));
		return ins;
	endfunction

	// in-order reference, r0 is never written so it reads zero
	task automatic model_exec(instr_t ins);
		word_t s;
		word_t t;
		word_t r;
		logic [15:0] imm;
		bit writes;
		imm = ins.imm;
		s = model_regs[ins.src_s];
		t = model_regs[imm[15:11]];
		writes = 1'b1;
		case (ins.opcode)
			OP_ADD:  r = s + t;
			OP_SUB:  r = s - t;
			OP_AND:  r = s & t;
			OP_OR:   r = s | t;
			OP_XOR:  r = s ^ t;
			OP_SLT:  r = ($signed(s) < $signed(t)) ? 32'd1 : 32'd0;
			OP_ADDI: r = s + {{16{imm[15]}}, imm};
			OP_LUI:  r = {imm, 16'h0000};
			OP_MUL:  r = s * t;
			default: begin
				r = '0;
				writes = 1'b0;
			end
		endcase
		if (writes && ins.dest != 0) begin
			model_regs[ins.dest] = r;
			exp_q[ins.dest].push_back(r);
			expected_writes++;
		end
	endtask

	task automatic check_wb(reg_addr_t a, word_t d, int port);
		word_t e;
		seen_writes++;
		if (exp_q[a].size() == 0) begin
			errors++;
			$display("unexpected write-back to r%0d on port %0d at %0t", a, port, $time);
		end else begin
			e = exp_q[a].pop_front();
			if (d !== e) begin
				errors++;
				$display("FAIL %0t: port %0d r%0d got %h, expected %h", $time, port, a, d, e);
			end
		end
	endtask

	function automatic int pending_results();
		int n;
		n = 0;
		for (int r = 0; r < NUM_REGS; r++)
			n += exp_q[r].size();
		return n;
	endfunction

	// write-back registers are stable at the falling edge
	always @(negedge clk) begin
		if (rstn) begin
			if (o_wb0_addr != '0)
				check_wb(o_wb0_addr, o_wb0_data, 0);
			if (o_wb1_addr != '0)
				check_wb(o_wb1_addr, o_wb1_data, 1);
		end
	end

	task automatic feed_program(output bit done);
		instr_t a;
		instr_t b;
		bit en;
		bit taken;
		int idx;
		int waited;
		idx = 0;
		done = 1'b1;
		while (idx < prog.size() && done) begin
			if ($urandom_range(7) == 0) begin
				i_vld <= 1'b0;
				@(posedge clk);
			end
			a = prog[idx];
			en = (idx + 1 < prog.size()) && ($urandom_range(3) != 0);
			b = en ? prog[idx + 1] : random_instr(1'b0);
			i_vld <= 1'b1;
			i_instr0 <= a;
			i_instr1 <= b;
			i_en1 <= en;
			taken = 1'b0;
			waited = 0;
			// pair held until an edge with busy low
			while (!taken && waited < ACCEPT_TIMEOUT) begin
				@(posedge clk);
				if (o_busy) begin
					busy_cycles++;
					waited++;
				end else begin
					taken = 1'b1;
				end
			end
			if (taken) begin
				model_exec(a);
				if (en)
					model_exec(b);
				idx += en ? 2 : 1;
			end else begin
				errors++;
				$display("timeout: instruction %0d not accepted in %0d cycles", idx, waited);
				done = 1'b0;
			end
		end
		i_vld <= 1'b0;
	endtask

	task automatic drain_results(output bit done);
		int waited;
		waited = 0;
		while (pending_results() != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		done = (pending_results() == 0);
		if (!done) begin
			errors++;
			$display("timeout: %0d results were never written back", pending_results());
		end
	endtask

	initial begin
		rstn <= 1'b0;
		i_vld <= 1'b0;
		i_instr0 <= '0;
		i_instr1 <= '0;
		i_en1 <= 1'b0;
		void'($urandom(SEED));
		alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_LUI};
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		// known values in r1..r7 before any random read
		for (int r = 1; r < 8; r++)
			prog.push_back({OP_ADDI, reg_addr_t'(r), 5'd0, 16'($urandom)});
		for (int n = 0; n < NUM_MIXED; n++)
			prog.push_back(random_instr(1'b0));
		for (int n = 0; n < NUM_BURST; n++)
			prog.push_back(random_instr(1'b1));
		for (int n = 0; n < NUM_MIXED / 2; n++)
			prog.push_back(random_instr(1'b0));

		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;
		@(negedge clk);
		if (o_busy !== 1'b0 || o_wb0_addr !== '0 || o_wb1_addr !== '0) begin
			errors++;
			$display("FAIL %0t: after reset busy=%b wb0_addr=%0d wb1_addr=%0d",
				$time, o_busy, o_wb0_addr, o_wb1_addr);
		end
		@(posedge clk);
		feed_program(ok);
		if (ok)
			drain_results(ok);
		// room for a stray duplicate write-back to show up
		repeat (10) @(posedge clk);
		if (seen_writes != expected_writes) begin
			errors++;
			$display("FAIL %0t: %0d write-backs seen, %0d expected",
				$time, seen_writes, expected_writes);
		end
		if (busy_cycles == 0) begin
			errors++;
			$display("o_busy never went high during the run");
		end
		$display("errors: %0d, write-backs: %0d of %0d, busy cycles: %0d",
			errors, seen_writes, expected_writes, busy_cycles);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- filelist.f
rtl/core_pkg.sv
rtl/issue_if.sv
rtl/instr_decoder.sv
rtl/issue_window.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/alu_mul_unit.sv
rtl/core_top.sv
tests/issue_window_chk.sv
tests/tb_core.sv

//--- run.sh
#!/bin/sh
# builds the core testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_core -f filelist.f -o tb_core_sim || exit 1
out=$(./obj_dir/tb_core_sim)
echo "$out"
echo "$out" | grep -qx "Verification passed" && echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation reported failure"; exit 1; }
